// File: compile.f
+incdir+testbench
logic/riscv_pkg.sv
logic/core_pkg.sv
logic/stage_buffer.sv
logic/id_stage.sv
logic/issue_stage.sv
logic/ex_stage.sv
logic/commit_stage.sv
logic/core_top.sv
testbench/tb_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_core -o tb_core &&
./obj_dir/tb_core ||
{ echo "simulation failed"; exit 1; }

// File: testbench/core_model.svh
//--------------------------------------------------------------------
// reference model: xorshift generator, register file, instruction step
//--------------------------------------------------------------------

`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// generator state, fixed seed
logic [31:0] rng_state = 32'd6;

riscv_pkg::xlen_t model_regs [riscv_pkg::NR_REGS];

function automatic logic [31:0] xorshift();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic void model_clear();
  for (int i = 0; i < riscv_pkg::NR_REGS; i++) begin
    model_regs[i] = '0;
  end
endfunction

// execute one instruction in program order, updates model_regs
function automatic void model_step(
  input  riscv_pkg::xlen_t     instr,
  output riscv_pkg::reg_addr_t rd,
  output riscv_pkg::xlen_t     wdata,
  output logic                 illegal
);
  logic [6:0]       opcode;
  logic [2:0]       f3;
  logic [6:0]       f7;
  logic             alt;
  riscv_pkg::xlen_t a;
  riscv_pkg::xlen_t b;
  opcode  = instr[6:0];
  f3      = instr[14:12];
  f7      = instr[31:25];
  alt     = (f7 == riscv_pkg::FUNCT7_ALT);
  rd      = instr[11:7];
  a       = model_regs[instr[19:15]];
  b       = {{20{instr[31]}}, instr[31:20]};
  wdata   = '0;
  illegal = 1'b0;
  case (opcode)
    riscv_pkg::OPCODE_OP: begin
      b       = model_regs[instr[24:20]];
      illegal = !(f7 == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
    end
    riscv_pkg::OPCODE_OP_IMM: begin
      if (f3 == 3'd1) begin
        illegal = (f7 != 7'h00);
      end
      if (f3 == 3'd5) begin
        illegal = !(f7 == 7'h00 || alt);
      end
      // addi has no subtract form
      alt = alt && (f3 == 3'd5);
    end
    riscv_pkg::OPCODE_LUI: begin
      a   = '0;
      b   = {instr[31:12], 12'h000};
      f3  = 3'd0;
      alt = 1'b0;
    end
    default: illegal = 1'b1;
  endcase
  if (!illegal) begin
    case (f3)
      3'd0: wdata = alt ? a - b : a + b;
      3'd1: wdata = a << b[4:0];
      3'd2: wdata = {31'b0, $signed(a) < $signed(b)};
      3'd3: wdata = {31'b0, a < b};
      3'd4: wdata = a ^ b;
      3'd5: begin
        if (alt) begin
          wdata = $signed(a) >>> b[4:0];
        end else begin
          wdata = a >> b[4:0];
        end
      end
      3'd6: wdata = a | b;
      default: wdata = a & b;
    endcase
    // x0 stays zero
    if (rd != '0) begin
      model_regs[rd] = wdata;
    end
  end
endfunction

`endif

// File: testbench/tb_core.sv
//--------------------------------------------------------------------
// testbench for core_top: random instruction stream, model compare
//--------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_core;

  localparam int NUM_INSTR = 400;
  localparam int TIMEOUT   = NUM_INSTR * 20 + 200;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 fetch_valid_i;
  logic                 fetch_ready_o;
  riscv_pkg::xlen_t     fetch_pc_i;
  riscv_pkg::xlen_t     fetch_instr_i;
  logic                 commit_valid_o;
  logic                 commit_ready_i;
  riscv_pkg::xlen_t     commit_pc_o;
  riscv_pkg::reg_addr_t commit_rd_o;
  riscv_pkg::xlen_t     commit_wdata_o;
  logic                 commit_ex_valid_o;
  riscv_pkg::xlen_t     commit_ex_cause_o;
  riscv_pkg::xlen_t     commit_ex_tval_o;
  riscv_pkg::xlen_t     retire_count_o;

  core_pkg::fetch_entry_t exp_q [$];
  int                     n_accepted = 0;
  int                     n_committed = 0;
  int                     n_legal = 0;
  int                     cycles = 0;
  logic                   running = 1'b0;
  logic                   fetch_fire = 1'b0;
  riscv_pkg::xlen_t       next_pc = 32'h0000_1000;

  `include "core_model.svh"

  core_top u_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_pc_i        (fetch_pc_i),
    .fetch_instr_i     (fetch_instr_i),
    .commit_valid_o    (commit_valid_o),
    .commit_ready_i    (commit_ready_i),
    .commit_pc_o       (commit_pc_o),
    .commit_rd_o       (commit_rd_o),
    .commit_wdata_o    (commit_wdata_o),
    .commit_ex_valid_o (commit_ex_valid_o),
    .commit_ex_cause_o (commit_ex_cause_o),
    .commit_ex_tval_o  (commit_ex_tval_o),
    .retire_count_o    (retire_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //------------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(input string name, input riscv_pkg::xlen_t got,
                            input riscv_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_reg(input string name, input riscv_pkg::reg_addr_t got,
                           input riscv_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run("register index mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      abort_run("flag mismatch");
    end
  endtask

  //------------------------------------------------------------------
  // stimulus generation
  //------------------------------------------------------------------
  // mostly x0..x7 so that hazards are frequent
  function automatic riscv_pkg::reg_addr_t pick_reg();
    logic [31:0] r;
    r = xorshift();
    return (r[3:0] == 4'd0) ? r[8:4] : {2'b00, r[6:4]};
  endfunction

  function automatic riscv_pkg::xlen_t build_instr();
    logic [31:0]          r;
    logic [2:0]           f3;
    logic [6:0]           f7;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    r = xorshift();
    if (r % 10 == 0) begin
      return xorshift();
    end
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    f3  = r[2:0];
    f7  = (r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? riscv_pkg::FUNCT7_ALT : 7'h00;
    if (r[11:8] < 4'd6) begin
      return {f7, rs2, rs1, f3, rd, riscv_pkg::OPCODE_OP};
    end else if (r[11:8] < 4'd13) begin
      // shifts carry shamt in the rs2 field
      if (f3 == 3'd1 || f3 == 3'd5) begin
        return {f7, rs2, rs1, f3, rd, riscv_pkg::OPCODE_OP_IMM};
      end
      return {r[27:16], rs1, f3, rd, riscv_pkg::OPCODE_OP_IMM};
    end
    return {r[31:12], rd, riscv_pkg::OPCODE_LUI};
  endfunction

  // inputs change 1 ns after the rising edge
  always @(posedge clk_i) begin
    if (running) begin
      #1;
      if (!fetch_valid_i || fetch_fire) begin
        if (n_accepted < NUM_INSTR && xorshift() % 4 != 0) begin
          fetch_valid_i = 1'b1;
          fetch_pc_i    = next_pc;
          fetch_instr_i = build_instr();
          next_pc       = next_pc + 4;
        end else begin
          fetch_valid_i = 1'b0;
        end
      end
      commit_ready_i = (xorshift() % 10) >= 3;
    end
  end

  //------------------------------------------------------------------
  // monitor, sampled mid-cycle when inputs and outputs are settled
  //------------------------------------------------------------------
  always @(negedge clk_i) begin
    core_pkg::fetch_entry_t exp_e;
    riscv_pkg::reg_addr_t   m_rd;
    riscv_pkg::xlen_t       m_wdata;
    logic                   m_illegal;
    if (running) begin
      fetch_fire = fetch_valid_i && fetch_ready_o;
      if (fetch_fire) begin
        exp_e.pc    = fetch_pc_i;
        exp_e.instr = fetch_instr_i;
        exp_q.push_back(exp_e);
        n_accepted++;
      end
      if (commit_valid_o && commit_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("commit at %0t with no outstanding instruction", $time);
          abort_run("unexpected commit");
        end
        exp_e = exp_q.pop_front();
        model_step(exp_e.instr, m_rd, m_wdata, m_illegal);
        check_word("commit_pc_o", commit_pc_o, exp_e.pc);
        check_reg("commit_rd_o", commit_rd_o, m_rd);
        check_word("commit_wdata_o", commit_wdata_o, m_wdata);
        check_flag("commit_ex_valid_o", commit_ex_valid_o, m_illegal);
        if (m_illegal) begin
          check_word("commit_ex_cause_o", commit_ex_cause_o, 32'd2);
          check_word("commit_ex_tval_o", commit_ex_tval_o, exp_e.instr);
        end else begin
          n_legal++;
        end
        n_committed++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, %0d of %0d committed", cycles, n_committed,
               NUM_INSTR);
      abort_run("run did not finish in time");
    end
  end

  initial begin
    int idle_cycles;
    rst_ni         = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_pc_i     = '0;
    fetch_instr_i  = '0;
    commit_ready_i = 1'b0;
    model_clear();
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("commit_valid_o", commit_valid_o, 1'b0);
    check_flag("fetch_ready_o", fetch_ready_o, 1'b1);
    check_word("retire_count_o", retire_count_o, '0);
    running = 1'b1;
    wait (n_accepted == NUM_INSTR);
    // no result offered for four cycles means the pipeline has drained
    idle_cycles = 0;
    while (idle_cycles < 4) begin
      @(negedge clk_i);
      idle_cycles = commit_valid_o ? 0 : idle_cycles + 1;
    end
    check_word("retire_count_o", retire_count_o, riscv_pkg::xlen_t'(n_legal));
    if (exp_q.size() != 0) begin
      $display("%0d instructions still outstanding at end of run", exp_q.size());
      abort_run("expected queue not empty");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/core_top.sv
//--------------------------------------------------------------------
// in-order core: decode, issue, execute and commit stages
//--------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module core_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  riscv_pkg::xlen_t     fetch_pc_i,
  input  riscv_pkg::xlen_t     fetch_instr_i,
  output logic                 commit_valid_o,
  input  logic                 commit_ready_i,
  output riscv_pkg::xlen_t     commit_pc_o,
  output riscv_pkg::reg_addr_t commit_rd_o,
  output riscv_pkg::xlen_t     commit_wdata_o,
  output logic                 commit_ex_valid_o,
  output riscv_pkg::xlen_t     commit_ex_cause_o,
  output riscv_pkg::xlen_t     commit_ex_tval_o,
  output riscv_pkg::xlen_t     retire_count_o
);

  //------------------------------------------------------------------
  // stage boundaries
  //------------------------------------------------------------------
  core_pkg::fetch_entry_t   fetch_entry;
  logic                     dec_valid;
  logic                     dec_ready;
  core_pkg::decoded_entry_t dec_entry;
  logic                     iss_valid;
  logic                     iss_ready;
  core_pkg::issue_entry_t   iss_entry;
  logic                     res_valid;
  logic                     res_ready;
  core_pkg::result_entry_t  res_entry;
  logic                     wb_we;
  riscv_pkg::reg_addr_t     wb_addr;
  riscv_pkg::xlen_t         wb_data;

  assign fetch_entry.pc    = fetch_pc_i;
  assign fetch_entry.instr = fetch_instr_i;

  id_stage u_id (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_entry_i (fetch_entry),
    .dec_valid_o   (dec_valid),
    .dec_ready_i   (dec_ready),
    .dec_entry_o   (dec_entry)
  );

  issue_stage u_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dec_valid_i (dec_valid),
    .dec_ready_o (dec_ready),
    .dec_entry_i (dec_entry),
    .iss_valid_o (iss_valid),
    .iss_ready_i (iss_ready),
    .iss_entry_o (iss_entry),
    .wb_we_i     (wb_we),
    .wb_addr_i   (wb_addr),
    .wb_data_i   (wb_data)
  );

  ex_stage u_ex (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .iss_valid_i (iss_valid),
    .iss_ready_o (iss_ready),
    .iss_entry_i (iss_entry),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_entry_o (res_entry)
  );

  commit_stage u_commit (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .res_valid_i       (res_valid),
    .res_ready_o       (res_ready),
    .res_entry_i       (res_entry),
    .commit_valid_o    (commit_valid_o),
    .commit_ready_i    (commit_ready_i),
    .commit_pc_o       (commit_pc_o),
    .commit_rd_o       (commit_rd_o),
    .commit_wdata_o    (commit_wdata_o),
    .commit_ex_valid_o (commit_ex_valid_o),
    .commit_ex_cause_o (commit_ex_cause_o),
    .commit_ex_tval_o  (commit_ex_tval_o),
    .wb_we_o           (wb_we),
    .wb_addr_o         (wb_addr),
    .wb_data_o         (wb_data),
    .retire_count_o    (retire_count_o)
  );

endmodule

`default_nettype wire

// File: logic/commit_stage.sv
//--------------------------------------------------------------------
// commit port, register write-back, exception report, retire count
//--------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module commit_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    res_valid_i,
  output logic                    res_ready_o,
  input  core_pkg::result_entry_t res_entry_i,
  output logic                    commit_valid_o,
  input  logic                    commit_ready_i,
  output riscv_pkg::xlen_t        commit_pc_o,
  output riscv_pkg::reg_addr_t    commit_rd_o,
  output riscv_pkg::xlen_t        commit_wdata_o,
  output logic                    commit_ex_valid_o,
  output riscv_pkg::xlen_t        commit_ex_cause_o,
  output riscv_pkg::xlen_t        commit_ex_tval_o,
  output logic                    wb_we_o,
  output riscv_pkg::reg_addr_t    wb_addr_o,
  output riscv_pkg::xlen_t        wb_data_o,
  output riscv_pkg::xlen_t        retire_count_o
);

  logic             commit_fire;
  riscv_pkg::xlen_t retire_q;

  // commit adds no register, back-pressure goes straight to execute
  assign commit_valid_o = res_valid_i;
  assign res_ready_o    = commit_ready_i;
  assign commit_fire    = res_valid_i & commit_ready_i;

  assign commit_pc_o    = res_entry_i.pc;
  assign commit_rd_o    = res_entry_i.rd;
  assign commit_wdata_o = res_entry_i.result;

  // illegal instruction trap, tval carries the instruction word
  assign commit_ex_valid_o = res_valid_i & res_entry_i.illegal;
  assign commit_ex_cause_o = res_entry_i.illegal ? riscv_pkg::CAUSE_ILLEGAL_INSTR : '0;
  assign commit_ex_tval_o  = res_entry_i.illegal ? res_entry_i.instr : '0;

  assign wb_we_o   = commit_fire & ~res_entry_i.illegal & (res_entry_i.rd != '0);
  assign wb_addr_o = res_entry_i.rd;
  assign wb_data_o = res_entry_i.result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_q <= '0;
    end else if (commit_fire && !res_entry_i.illegal) begin
      retire_q <= retire_q + 1'b1;
    end
  end

  assign retire_count_o = retire_q;

endmodule

`default_nettype wire

// File: logic/ex_stage.sv
//--------------------------------------------------------------------
// integer ALU and execute result buffer
//--------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module ex_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    iss_valid_i,
  output logic                    iss_ready_o,
  input  core_pkg::issue_entry_t  iss_entry_i,
  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  output core_pkg::result_entry_t res_entry_o
);

  riscv_pkg::xlen_t        a;
  riscv_pkg::xlen_t        b;
  logic [4:0]              shamt;
  riscv_pkg::xlen_t        alu_out;
  core_pkg::result_entry_t res;

  assign a     = iss_entry_i.op_a;
  assign b     = iss_entry_i.op_b;
  assign shamt = b[4:0];

  always_comb begin
    case (iss_entry_i.alu_op)
      core_pkg::ALU_ADD:  alu_out = a + b;
      core_pkg::ALU_SUB:  alu_out = a - b;
      core_pkg::ALU_SLL:  alu_out = a << shamt;
      core_pkg::ALU_SLT:  alu_out = riscv_pkg::xlen_t'($signed(a) < $signed(b));
      core_pkg::ALU_SLTU: alu_out = riscv_pkg::xlen_t'(a < b);
      core_pkg::ALU_XOR:  alu_out = a ^ b;
      core_pkg::ALU_SRL:  alu_out = a >> shamt;
      core_pkg::ALU_SRA:  alu_out = riscv_pkg::xlen_t'($signed(a) >>> shamt);
      core_pkg::ALU_OR:   alu_out = a | b;
      default:            alu_out = a & b;
    endcase
  end

  always_comb begin
    res.pc      = iss_entry_i.pc;
    res.instr   = iss_entry_i.instr;
    res.rd      = iss_entry_i.rd;
    res.result  = iss_entry_i.illegal ? '0 : alu_out;
    res.illegal = iss_entry_i.illegal;
  end

  stage_buffer #(
    .T (core_pkg::result_entry_t)
  ) u_res_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (iss_valid_i),
    .ready_o (iss_ready_o),
    .data_i  (res),
    .valid_o (res_valid_o),
    .ready_i (res_ready_i),
    .data_o  (res_entry_o)
  );

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
//--------------------------------------------------------------------
// register file, scoreboard, operand read and issue buffer
//--------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module issue_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dec_valid_i,
  output logic                     dec_ready_o,
  input  core_pkg::decoded_entry_t dec_entry_i,
  output logic                     iss_valid_o,
  input  logic                     iss_ready_i,
  output core_pkg::issue_entry_t   iss_entry_o,
  input  logic                     wb_we_i,
  input  riscv_pkg::reg_addr_t     wb_addr_i,
  input  riscv_pkg::xlen_t         wb_data_i
);

  localparam int unsigned CW = core_pkg::PEND_CNT_W;

  riscv_pkg::xlen_t       regs_q [riscv_pkg::NR_REGS];
  logic [CW-1:0]          pend_q [riscv_pkg::NR_REGS];
  logic                   rs1_hit_wb;
  logic                   rs2_hit_wb;
  logic                   rs1_busy;
  logic                   rs2_busy;
  logic                   stall;
  logic                   buf_ready;
  logic                   set_pend;
  riscv_pkg::xlen_t       rs1_val;
  riscv_pkg::xlen_t       rs2_val;
  core_pkg::issue_entry_t iss;

  //------------------------------------------------------------------
  // operand read with write-back bypass
  //------------------------------------------------------------------
  assign rs1_hit_wb = wb_we_i && (wb_addr_i == dec_entry_i.rs1);
  assign rs2_hit_wb = wb_we_i && (wb_addr_i == dec_entry_i.rs2);

  assign rs1_val = (dec_entry_i.rs1 == '0) ? '0 :
                   rs1_hit_wb ? wb_data_i : regs_q[dec_entry_i.rs1];
  assign rs2_val = (dec_entry_i.rs2 == '0) ? '0 :
                   rs2_hit_wb ? wb_data_i : regs_q[dec_entry_i.rs2];

  // busy unless the last writer retires this cycle
  assign rs1_busy = pend_q[dec_entry_i.rs1] > CW'(rs1_hit_wb);
  assign rs2_busy = ~dec_entry_i.use_imm && (pend_q[dec_entry_i.rs2] > CW'(rs2_hit_wb));
  assign stall    = rs1_busy | rs2_busy;

  assign dec_ready_o = buf_ready & ~stall;
  assign set_pend    = dec_valid_i & dec_ready_o & ~dec_entry_i.illegal &
                       (dec_entry_i.rd != '0);

  always_comb begin
    iss.pc      = dec_entry_i.pc;
    iss.instr   = dec_entry_i.instr;
    iss.alu_op  = dec_entry_i.alu_op;
    iss.op_a    = rs1_val;
    iss.op_b    = dec_entry_i.use_imm ? dec_entry_i.imm : rs2_val;
    iss.rd      = dec_entry_i.rd;
    iss.illegal = dec_entry_i.illegal;
  end

  //------------------------------------------------------------------
  // register file and scoreboard
  //------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < riscv_pkg::NR_REGS; i++) begin
        regs_q[i] <= '0;
        pend_q[i] <= '0;
      end
    end else begin
      if (wb_we_i) begin
        regs_q[wb_addr_i] <= wb_data_i;
      end
      // count of uncommitted writers, so a WAW pair keeps the register busy
      for (int i = 0; i < riscv_pkg::NR_REGS; i++) begin
        pend_q[i] <= pend_q[i]
                   + CW'(set_pend && dec_entry_i.rd == riscv_pkg::reg_addr_t'(i))
                   - CW'(wb_we_i && wb_addr_i == riscv_pkg::reg_addr_t'(i));
      end
    end
  end

  stage_buffer #(
    .T (core_pkg::issue_entry_t)
  ) u_iss_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (dec_valid_i & ~stall),
    .ready_o (buf_ready),
    .data_i  (iss),
    .valid_o (iss_valid_o),
    .ready_i (iss_ready_i),
    .data_o  (iss_entry_o)
  );

endmodule

`default_nettype wire

// File: logic/id_stage.sv
//--------------------------------------------------------------------
// decoder for OP, OP-IMM and LUI with illegal detection
//--------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module id_stage (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_valid_i,
  output logic                       fetch_ready_o,
  input  core_pkg::fetch_entry_t     fetch_entry_i,
  output logic                       dec_valid_o,
  input  logic                       dec_ready_i,
  output core_pkg::decoded_entry_t   dec_entry_o
);

  riscv_pkg::xlen_t         instr;
  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic                     f7_zero;
  logic                     f7_alt;
  core_pkg::alu_op_t        func_op;
  core_pkg::decoded_entry_t dec;

  assign instr   = fetch_entry_i.instr;
  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == riscv_pkg::FUNCT7_ALT);

  // alu function from funct3, alt bit picks sub/sra
  always_comb begin
    case (funct3)
      riscv_pkg::F3_ADD_SUB: func_op = core_pkg::ALU_ADD;
      riscv_pkg::F3_SLL:     func_op = core_pkg::ALU_SLL;
      riscv_pkg::F3_SLT:     func_op = core_pkg::ALU_SLT;
      riscv_pkg::F3_SLTU:    func_op = core_pkg::ALU_SLTU;
      riscv_pkg::F3_XOR:     func_op = core_pkg::ALU_XOR;
      riscv_pkg::F3_SRL_SRA: func_op = f7_alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      riscv_pkg::F3_OR:      func_op = core_pkg::ALU_OR;
      default:               func_op = core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    dec         = '0;
    dec.pc      = fetch_entry_i.pc;
    dec.instr   = instr;
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.rd      = instr[11:7];
    dec.alu_op  = func_op;
    dec.use_imm = 1'b1;
    dec.imm     = {{20{instr[31]}}, instr[31:20]};
    case (opcode)
      riscv_pkg::OPCODE_OP: begin
        dec.use_imm = 1'b0;
        if (funct3 == riscv_pkg::F3_ADD_SUB && f7_alt) begin
          dec.alu_op = core_pkg::ALU_SUB;
        end
        // only add/sub and srl/sra have an alternate encoding
        dec.illegal = ~(f7_zero | (f7_alt & (funct3 == riscv_pkg::F3_ADD_SUB ||
                                             funct3 == riscv_pkg::F3_SRL_SRA)));
      end
      riscv_pkg::OPCODE_OP_IMM: begin
        if (funct3 == riscv_pkg::F3_SLL) begin
          dec.illegal = ~f7_zero;
        end else if (funct3 == riscv_pkg::F3_SRL_SRA) begin
          dec.illegal = ~(f7_zero | f7_alt);
        end
      end
      riscv_pkg::OPCODE_LUI: begin
        // x0 plus the upper immediate
        dec.rs1    = '0;
        dec.alu_op = core_pkg::ALU_ADD;
        dec.imm    = {instr[31:12], 12'b0};
      end
      default: dec.illegal = 1'b1;
    endcase
  end

  stage_buffer #(
    .T (core_pkg::decoded_entry_t)
  ) u_dec_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (fetch_valid_i),
    .ready_o (fetch_ready_o),
    .data_i  (dec),
    .valid_o (dec_valid_o),
    .ready_i (dec_ready_i),
    .data_o  (dec_entry_o)
  );

endmodule

`default_nettype wire

// File: logic/stage_buffer.sv
//--------------------------------------------------------------------
// one-entry valid/ready pipeline register, payload set by type
//--------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module stage_buffer #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic valid_q;
  T     data_q;

  // free slot, or the held entry leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
//--------------------------------------------------------------------
// pipeline entry structs, ALU operations, scoreboard sizing
//--------------------------------------------------------------------

`default_nettype none

package core_pkg;

  // in-flight writers per register: issue buffer plus execute buffer
  localparam int unsigned PEND_CNT_W = 2;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  //------------------------------------------------------------------
  // stage payloads
  //------------------------------------------------------------------
  typedef struct packed {
    riscv_pkg::xlen_t pc;
    riscv_pkg::xlen_t instr;
  } fetch_entry_t;

  typedef struct packed {
    riscv_pkg::xlen_t     pc;
    riscv_pkg::xlen_t     instr;
    alu_op_t              alu_op;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::reg_addr_t rd;
    logic                 use_imm;
    riscv_pkg::xlen_t     imm;
    logic                 illegal;
  } decoded_entry_t;

  typedef struct packed {
    riscv_pkg::xlen_t     pc;
    riscv_pkg::xlen_t     instr;
    alu_op_t              alu_op;
    riscv_pkg::xlen_t     op_a;
    riscv_pkg::xlen_t     op_b;
    riscv_pkg::reg_addr_t rd;
    logic                 illegal;
  } issue_entry_t;

  typedef struct packed {
    riscv_pkg::xlen_t     pc;
    riscv_pkg::xlen_t     instr;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::xlen_t     result;
    logic                 illegal;
  } result_entry_t;

endpackage

`default_nettype wire

// File: logic/riscv_pkg.sv
//--------------------------------------------------------------------
// RV32I subset: data widths, major opcodes, funct fields and the
// illegal-instruction exception cause
//--------------------------------------------------------------------

`default_nettype none

package riscv_pkg;

  // data path
  localparam int unsigned XLEN    = 32;
  localparam int unsigned NR_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;

  //------------------------------------------------------------------
  // major opcodes
  //------------------------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

  //------------------------------------------------------------------
  // funct3 of the integer ALU group, shared by OP and OP-IMM
  //------------------------------------------------------------------
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // selects sub and sra, also srai in the immediate group
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // mcause encoding
  localparam xlen_t CAUSE_ILLEGAL_INSTR = 32'd2;

endpackage

`default_nettype wire
